// ==== design/tag_compare_evict.sv ====
/* Hit detection and victim selection
   Compares the read entries with the request and keeps a round-robin
   pointer per set */

`timescale 1ns/1ps

`include "tag_store_defines.svh"

module tag_compare_evict (
  input  logic                                     clk_i,
  input  logic                                     rst_i,
  input  tag_store_pkg::store_req_t                req_q_i,
  input  tag_store_pkg::tag_entry_t [`TS_WAYS-1:0] entries_i,
  input  tag_store_pkg::way_ind_t                  lock_i,
  input  logic                                     miss_wr_i,
  output tag_store_pkg::store_res_t                result_o,
  output logic                                     hit_dirty_o
);

  import tag_store_pkg::*;

  way_ind_t   hit_vec;
  way_ind_t   eligible;
  way_ind_t   free_vec;
  way_num_t   hit_num;
  way_num_t   flush_num;
  way_num_t   victim_num;
  logic       victim_found;
  way_num_t   sel_num;
  tag_entry_t sel_entry;
  // Victim of the previous cycle for the pointer update
  way_num_t   victim_q;
  way_num_t   rr_q [`TS_SETS];

  // Lowest set bit as way number
  function automatic way_num_t first_set(input way_ind_t vec);
    way_num_t num;
    num = '0;
    for (int i = `TS_WAYS - 1; i >= 0; i--) begin
      if (vec[i]) begin
        num = way_num_t'(i);
      end
    end
    return num;
  endfunction

  always_comb begin
    for (int w = 0; w < `TS_WAYS; w++) begin
      hit_vec[w]  = req_q_i.indicator[w] && entries_i[w].valid &&
                    (entries_i[w].tag == req_q_i.tag);
      free_vec[w] = req_q_i.indicator[w] && !lock_i[w] && !entries_i[w].valid;
    end
  end

  assign eligible  = req_q_i.indicator & ~lock_i;
  assign hit_num   = first_set(hit_vec);
  assign flush_num = first_set(req_q_i.indicator);

  // Free way first, else first eligible way from the set pointer on
  always_comb begin
    way_num_t cand;
    cand         = '0;
    victim_num   = first_set(free_vec);
    victim_found = |free_vec;
    if (!victim_found) begin
      // Downward walk so the way nearest the pointer wins
      for (int i = `TS_WAYS - 1; i >= 0; i--) begin
        cand = way_num_t'((int'(rr_q[req_q_i.index]) + i) % `TS_WAYS);
        if (eligible[cand]) begin
          victim_num   = cand;
          victim_found = 1'b1;
        end
      end
    end
  end

  assign sel_num   = (req_q_i.mode == FLUSH) ? flush_num : victim_num;
  assign sel_entry = entries_i[sel_num];

  always_comb begin
    result_o    = '0;
    hit_dirty_o = 1'b0;
    if ((req_q_i.mode == LOOKUP) && (|hit_vec)) begin
      result_o.indicator = hit_vec;
      result_o.hit       = 1'b1;
      hit_dirty_o        = entries_i[hit_num].dirty;
    end else if ((req_q_i.mode == FLUSH) || victim_found) begin
      result_o.indicator = (req_q_i.mode == FLUSH) ? req_q_i.indicator :
                           (way_ind_t'(1) << victim_num);
      result_o.evict     = sel_entry.valid & sel_entry.dirty;
      // Invalid entries report a zero tag
      result_o.evict_tag = sel_entry.valid ? sel_entry.tag : '0;
    end
  end

  always_ff @(posedge clk_i) begin
    victim_q <= victim_num;
  end

  // Write strobe advances the pointer only for a lookup that missed
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      for (int s = 0; s < `TS_SETS; s++) begin
        rr_q[s] <= '0;
      end
    end else if (miss_wr_i && (req_q_i.mode == LOOKUP) && !(|hit_vec)) begin
      rr_q[req_q_i.index] <= (victim_q == way_num_t'(`TS_WAYS - 1)) ? '0 : victim_q + 1'b1;
    end
  end

endmodule

// ==== design/tag_read_timer.sv ====
/* Read latency timer
   Pulses once when the data of a tag read become valid */

`timescale 1ns/1ps

`include "tag_store_defines.svh"

module tag_read_timer (
  input  logic clk_i,
  input  logic rst_i,
  input  logic start_i,
  output logic done_o
);

  localparam int unsigned cnt_w = $clog2(`TS_READ_LAT + 1);

  typedef logic [cnt_w-1:0] cnt_t;

  // Edges still to wait
  cnt_t cnt_q;
  // A read is outstanding
  logic armed_q;

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      cnt_q   <= '0;
      armed_q <= 1'b0;
    end else if (start_i) begin
      // The edge that samples start already counts as the first
      cnt_q   <= cnt_t'(`TS_READ_LAT - 1);
      armed_q <= 1'b1;
    end else if (armed_q) begin
      if (cnt_q == '0) begin
        armed_q <= 1'b0;
      end else begin
        cnt_q <= cnt_q - 1'b1;
      end
    end
  end

  assign done_o = armed_q && (cnt_q == '0);

endmodule

// ==== design/tag_store_fsm.sv ====
/* Tag store controller
   Takes one request at a time, waits for read data, presents the response
   and issues the write back */

`timescale 1ns/1ps

module tag_store_fsm (
  input  logic                      clk_i,
  input  logic                      rst_i,
  input  tag_store_pkg::store_req_t req_i,
  input  logic                      valid_i,
  output logic                      ready_o,
  output tag_store_pkg::store_res_t res_o,
  output logic                      valid_o,
  input  logic                      ready_i,
  output tag_store_pkg::store_req_t req_q_o,
  output logic                      rd_o,
  input  logic                      rd_done_i,
  input  tag_store_pkg::store_res_t result_i,
  input  logic                      hit_dirty_i,
  output logic                      wr_o,
  output tag_store_pkg::way_ind_t   wr_mask_o,
  output tag_store_pkg::tag_entry_t wr_entry_o
);

  import tag_store_pkg::*;

  ctrl_state_e state_q;
  ctrl_state_e state_d;
  // Accepted request
  store_req_t  req_q;
  // Response held while valid_o is high
  store_res_t  res_q;
  // Dirty bit of the hit way at capture time
  logic        hit_dirty_q;
  // Read strobe is a pulse in the first READ cycle
  logic        rd_q;
  logic        accept;

  assign accept = (state_q == IDLE) && valid_i;

  // Next state
  always_comb begin
    state_d = state_q;
    unique case (state_q)
      IDLE: begin
        if (valid_i) begin
          state_d = READ;
        end
      end
      READ: begin
        // Timer marks the cycle where read data are valid
        if (rd_done_i) begin
          state_d = RESP;
        end
      end
      RESP: begin
        if (ready_i) begin
          state_d = WRITE;
        end
      end
      WRITE: begin
        state_d = IDLE;
      end
      default: begin
        state_d = IDLE;
      end
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      state_q <= IDLE;
      rd_q    <= 1'b0;
    end else begin
      state_q <= state_d;
      rd_q    <= accept;
    end
  end

  // Request payload
  always_ff @(posedge clk_i) begin
    if (accept) begin
      req_q <= req_i;
    end
  end

  // Comparison result frozen on entry to RESP
  always_ff @(posedge clk_i) begin
    if ((state_q == READ) && rd_done_i) begin
      res_q       <= result_i;
      hit_dirty_q <= hit_dirty_i;
    end
  end

  assign ready_o = (state_q == IDLE);
  assign valid_o = (state_q == RESP);
  assign res_o   = res_q;
  assign req_q_o = req_q;
  assign rd_o    = rd_q;

  // Write back decision
  always_comb begin
    wr_o       = 1'b0;
    wr_mask_o  = res_q.indicator;
    wr_entry_o = '0;
    if (state_q == WRITE) begin
      if (req_q.mode == FLUSH) begin
        // Flushed entry is cleared
        wr_o = 1'b1;
      end else if (res_q.hit) begin
        // Only a clean hit with a dirty request needs an update
        if (req_q.dirty && !hit_dirty_q) begin
          wr_o       = 1'b1;
          wr_entry_o = tag_entry_t'{valid: 1'b1, dirty: 1'b1, tag: req_q.tag};
        end
      end else if (|res_q.indicator) begin
        // Miss refill of the victim way
        wr_o       = 1'b1;
        wr_entry_o = tag_entry_t'{valid: 1'b1, dirty: req_q.dirty, tag: req_q.tag};
      end
    end
  end

endmodule

// ==== design/tag_store_pkg.sv ====
/* Tag store types
   Widths, stored entry, request and response formats, controller states */

`include "tag_store_defines.svh"

package tag_store_pkg;

  // One bit per way
  typedef logic [`TS_WAYS-1:0] way_ind_t;

  // Binary way number
  typedef logic [$clog2(`TS_WAYS)-1:0] way_num_t;

  // Set index
  typedef logic [$clog2(`TS_SETS)-1:0] index_t;

  // Stored tag
  typedef logic [`TS_TAG_W-1:0] tag_t;

  // One entry as held by the storage
  typedef struct packed {
    logic valid;
    logic dirty;
    tag_t tag;
  } tag_entry_t;

  // Request kinds
  typedef enum logic {
    LOOKUP,
    FLUSH
  } tag_mode_e;

  typedef struct packed {
    tag_mode_e mode;
    way_ind_t  indicator;
    index_t    index;
    tag_t      tag;
    logic      dirty;
  } store_req_t;

  typedef struct packed {
    way_ind_t indicator;
    logic     hit;
    logic     evict;
    tag_t     evict_tag;
  } store_res_t;

  // Controller sequence
  typedef enum logic [1:0] {
    IDLE,
    READ,
    RESP,
    WRITE
  } ctrl_state_e;

endpackage

// ==== design/tag_store_top.sv ====
/* Tag store for a set-associative last-level cache
   Lookup and flush requests over valid/ready handshakes on both sides */

`timescale 1ns/1ps

`include "tag_store_defines.svh"

module tag_store_top (
  input  logic                      clk_i,
  input  logic                      rst_i,
  input  tag_store_pkg::store_req_t req_i,
  input  logic                      valid_i,
  output logic                      ready_o,
  input  tag_store_pkg::way_ind_t   lock_i,
  output tag_store_pkg::store_res_t res_o,
  output logic                      valid_o,
  input  logic                      ready_i
);

  import tag_store_pkg::*;

  // Registered request shared by storage and comparison
  store_req_t                req_q;
  logic                      rd;
  logic                      rd_done;
  logic                      wr;
  way_ind_t                  wr_mask;
  tag_entry_t                wr_entry;
  // Entries of all ways of the addressed set
  tag_entry_t [`TS_WAYS-1:0] entries;
  store_res_t                result;
  logic                      hit_dirty;

  tag_store_fsm tag_store_fsm_inst (
    .clk_i       (clk_i),
    .rst_i       (rst_i),
    .req_i       (req_i),
    .valid_i     (valid_i),
    .ready_o     (ready_o),
    .res_o       (res_o),
    .valid_o     (valid_o),
    .ready_i     (ready_i),
    .req_q_o     (req_q),
    .rd_o        (rd),
    .rd_done_i   (rd_done),
    .result_i    (result),
    .hit_dirty_i (hit_dirty),
    .wr_o        (wr),
    .wr_mask_o   (wr_mask),
    .wr_entry_o  (wr_entry)
  );

  // Started by the same strobe as the storage read
  tag_read_timer tag_read_timer_inst (
    .clk_i   (clk_i),
    .rst_i   (rst_i),
    .start_i (rd),
    .done_o  (rd_done)
  );

  tag_way_array tag_way_array_inst (
    .clk_i      (clk_i),
    .rst_i      (rst_i),
    .rd_i       (rd),
    .wr_i       (wr),
    .index_i    (req_q.index),
    .wr_mask_i  (wr_mask),
    .wr_entry_i (wr_entry),
    .entries_o  (entries)
  );

  tag_compare_evict tag_compare_evict_inst (
    .clk_i       (clk_i),
    .rst_i       (rst_i),
    .req_q_i     (req_q),
    .entries_i   (entries),
    .lock_i      (lock_i),
    .miss_wr_i   (wr),
    .result_o    (result),
    .hit_dirty_o (hit_dirty)
  );

endmodule

// ==== design/tag_way_array.sv ====
/* Tag storage
   Valid, dirty and tag of every way in every set with a fixed read latency */

`timescale 1ns/1ps

`include "tag_store_defines.svh"

module tag_way_array (
  input  logic                                     clk_i,
  input  logic                                     rst_i,
  input  logic                                     rd_i,
  input  logic                                     wr_i,
  input  tag_store_pkg::index_t                    index_i,
  input  tag_store_pkg::way_ind_t                  wr_mask_i,
  input  tag_store_pkg::tag_entry_t                wr_entry_i,
  output tag_store_pkg::tag_entry_t [`TS_WAYS-1:0] entries_o
);

  import tag_store_pkg::*;

  // Valid bits per set
  way_ind_t valid_q [`TS_SETS];
  // Dirty bits per set
  way_ind_t dirty_mem [`TS_SETS];
  tag_t     tag_mem [`TS_SETS][`TS_WAYS];

  // Read data pipeline
  // Stage 0 is the array output
  tag_entry_t [`TS_WAYS-1:0] rd_pipe_q [`TS_READ_LAT];

  // Valid bits start cleared
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      for (int s = 0; s < `TS_SETS; s++) begin
        valid_q[s] <= '0;
      end
    end else if (wr_i) begin
      for (int w = 0; w < `TS_WAYS; w++) begin
        if (wr_mask_i[w]) begin
          valid_q[index_i][w] <= wr_entry_i.valid;
        end
      end
    end
  end

  // Dirty and tag storage
  always_ff @(posedge clk_i) begin
    if (wr_i) begin
      for (int w = 0; w < `TS_WAYS; w++) begin
        if (wr_mask_i[w]) begin
          dirty_mem[index_i][w] <= wr_entry_i.dirty;
          tag_mem[index_i][w]   <= wr_entry_i.tag;
        end
      end
    end
  end

  // Stage 0 loads on a read and holds
  // Later stages follow every edge so the output holds too
  always_ff @(posedge clk_i) begin
    if (rd_i) begin
      for (int w = 0; w < `TS_WAYS; w++) begin
        rd_pipe_q[0][w] <= tag_entry_t'{
          valid: valid_q[index_i][w],
          dirty: dirty_mem[index_i][w],
          tag:   tag_mem[index_i][w]
        };
      end
    end
    for (int k = 1; k < `TS_READ_LAT; k++) begin
      rd_pipe_q[k] <= rd_pipe_q[k-1];
    end
  end

  assign entries_o = rd_pipe_q[`TS_READ_LAT-1];

endmodule

// ==== include/tag_store_defines.svh ====
/* Tag store configuration
   Geometry of the tag array and read latency of its storage */

`ifndef TAG_STORE_DEFINES_SVH
`define TAG_STORE_DEFINES_SVH

// Associativity
// Also the width of every way indicator and lock vector
`define TS_WAYS 4

// Number of sets addressed by the request index
`define TS_SETS 16

// Width of the stored tag
`define TS_TAG_W 8

// Edges from read strobe to valid read data
// Timer and storage pipeline are both sized from this
`define TS_READ_LAT 2

`endif

// ==== list.f ====
+incdir+include
design/tag_store_pkg.sv
design/tag_store_fsm.sv
design/tag_read_timer.sv
design/tag_way_array.sv
design/tag_compare_evict.sv
design/tag_store_top.sv
testbench/tag_store_assertions.sv
testbench/tag_store_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the tag store testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal -f list.f \
  --top-module tag_store_tb -Mdir obj_dir -o tag_store_sim
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/tag_store_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -q "^Finished with no errors$" "$LOG"; then
  exit 0
fi
echo "Pass message not found in $LOG"
exit 1

// ==== testbench/tag_store_assertions.sv ====
/* Tag store handshake checks
   Response hold under back-pressure, one-hot response way, no request
   acceptance while a response is pending */

`timescale 1ns/1ps

module tag_store_assertions (
  input logic                      clk_i,
  input logic                      rst_i,
  input logic                      ready_o,
  input tag_store_pkg::store_res_t res_o,
  input logic                      valid_o,
  input logic                      ready_i
);

  import tag_store_pkg::*;

  // A stalled response keeps valid_o and its payload
  property res_held_until_ready;
    @(posedge clk_i) disable iff (rst_i)
      (valid_o && !ready_i) |=> (valid_o && $stable(res_o));
  endproperty

  // Exactly one way named in every response
  property res_way_one_hot;
    @(posedge clk_i) disable iff (rst_i)
      valid_o |-> $onehot(res_o.indicator);
  endproperty

  // Only one request in flight
  property no_accept_during_res;
    @(posedge clk_i) disable iff (rst_i)
      valid_o |-> !ready_o;
  endproperty

  hold_chk: assert property (res_held_until_ready)
    else $error("res_o or valid_o changed before ready_i");

  one_hot_chk: assert property (res_way_one_hot)
    else $error("response indicator is not one-hot");

  ready_chk: assert property (no_accept_during_res)
    else $error("ready_o high while a response is pending");

endmodule

// ==== testbench/tag_store_golden.txt ====
// mode indicator index tag dirty lock | exp_hit exp_evict exp_indicator exp_evict_tag | stall
// mode 0 lookup, 1 flush, e ends the list; stall 0 picks a random stall of 0 to 7
0 f 1 a5 0 0  0 0 1 00  3
0 f 1 a5 0 0  1 0 1 00  0
0 f 1 a5 1 0  1 0 1 00  2
1 1 1 00 0 0  0 1 1 a5  0
0 f 1 a5 0 0  0 0 1 00  1
1 2 1 00 0 0  0 0 2 00  0
1 1 1 00 0 0  0 0 1 a5  4
0 f 2 10 1 0  0 0 1 00  0
0 f 2 11 0 0  0 0 2 00  1
0 f 2 12 1 0  0 0 4 00  0
0 f 2 13 0 0  0 0 8 00  5
0 f 2 20 0 0  0 1 1 10  0
0 f 2 21 1 0  0 0 2 11  2
0 f 2 22 0 0  0 1 4 12  0
0 f 2 23 0 0  0 0 8 13  0
0 f 2 24 0 0  0 0 1 20  7
0 f 2 21 0 2  1 0 2 00  0
0 f 2 30 0 2  0 0 4 22  3
0 f 2 31 0 8  0 0 1 24  0
0 f 2 32 1 2  0 0 4 30  1
0 3 2 33 0 1  0 1 2 21  0
0 f 3 40 0 1  0 0 2 00  6
0 c 4 50 0 0  0 0 4 00  0
e 0 0 00 0 0  0 0 0 00  0

// ==== testbench/tag_store_tb.sv ====
/* Tag store testbench
   Replays the golden request list, checks every response, its latency
   and its behavior under ready_i stalls */

`timescale 1ns/1ps

`include "tag_store_defines.svh"

module tag_store_tb;

  import tag_store_pkg::*;

  // Words per golden record
  localparam int rec_words = 11;
  localparam int max_recs = 64;
  localparam int reset_cycles = 8;
  // Worst case edges of one request
  localparam int cycles_per_test = `TS_READ_LAT + 3 + 8;

  logic       clk_i;
  logic       rst_i;
  store_req_t req_i;
  logic       valid_i;
  logic       ready_o;
  way_ind_t   lock_i;
  store_res_t res_o;
  logic       valid_o;
  logic       ready_i;

  // Golden words in file order
  logic [7:0] gold [rec_words*max_recs];

  int err_cnt;
  int cycle_cnt;
  int cycle_limit;

  tag_store_top tag_store_top_inst (
    .clk_i   (clk_i),
    .rst_i   (rst_i),
    .req_i   (req_i),
    .valid_i (valid_i),
    .ready_o (ready_o),
    .lock_i  (lock_i),
    .res_o   (res_o),
    .valid_o (valid_o),
    .ready_i (ready_i)
  );

  bind tag_store_top tag_store_assertions tag_store_assertions_inst (
    .clk_i   (clk_i),
    .rst_i   (rst_i),
    .ready_o (ready_o),
    .res_o   (res_o),
    .valid_o (valid_o),
    .ready_i (ready_i)
  );

  // 100 ns clock
  always #50 clk_i = ~clk_i;

  // Watchdog sized from the number of records
  always @(posedge clk_i) begin
    cycle_cnt = cycle_cnt + 1;
    if ((cycle_limit > 0) && (cycle_cnt >= cycle_limit)) begin
      $display("Timeout after %0d cycles, the DUT stopped answering", cycle_cnt);
      $display("Finished with errors");
      $finish;
    end
  end

  // Stall generator
  function automatic logic [31:0] lcg_next(input logic [31:0] state);
    return state * 32'd1103515245 + 32'd12345;
  endfunction

  // Records before the end marker, -1 without one
  function automatic int count_records();
    int n;
    n = -1;
    for (int r = max_recs - 1; r >= 0; r--) begin
      if (gold[r*rec_words] == 8'h0e) begin
        n = r;
      end
    end
    return n;
  endfunction

  task automatic report_mismatch(input string name, input logic [31:0] exp_val,
                                 input logic [31:0] act_val);
    $display("mismatch at %0t ns: %s expected %0h got %0h", $time, name, exp_val, act_val);
    err_cnt++;
  endtask

  initial begin
    int          n_tests;
    int          base;
    int          stall;
    int          edges;
    int          test_start;
    int          passed;
    int          failed;
    logic [31:0] rng;
    store_res_t  exp_res;
    clk_i       = 1'b0;
    rst_i       = 1'b1;
    req_i       = '0;
    valid_i     = 1'b0;
    lock_i      = '0;
    ready_i     = 1'b0;
    err_cnt     = 0;
    cycle_cnt   = 0;
    cycle_limit = 0;
    passed      = 0;
    failed      = 0;
    rng         = 32'd80039;

    $readmemh("testbench/tag_store_golden.txt", gold);
    n_tests = count_records();
    if (n_tests < 0) begin
      $display("Golden file has no end marker, no test was run");
      err_cnt++;
      n_tests = 0;
    end
    cycle_limit = n_tests * cycles_per_test + reset_cycles + 50;

    repeat (reset_cycles) @(posedge clk_i);
    @(negedge clk_i);
    rst_i = 1'b0;

    for (int t = 0; t < n_tests; t++) begin
      base       = t * rec_words;
      test_start = err_cnt;
      req_i.mode      = tag_mode_e'(gold[base][0]);
      req_i.indicator = way_ind_t'(gold[base+1]);
      req_i.index     = index_t'(gold[base+2]);
      req_i.tag       = tag_t'(gold[base+3]);
      req_i.dirty     = gold[base+4][0];
      lock_i          = way_ind_t'(gold[base+5]);
      exp_res.hit       = gold[base+6][0];
      exp_res.evict     = gold[base+7][0];
      exp_res.indicator = way_ind_t'(gold[base+8]);
      exp_res.evict_tag = tag_t'(gold[base+9]);
      stall = int'(gold[base+10]);
      if (stall == 0) begin
        rng   = lcg_next(rng);
        stall = int'(rng[18:16]);
      end
      valid_i = 1'b1;
      while (!ready_o) begin
        @(negedge clk_i);
      end
      // Next rising edge takes the request
      @(negedge clk_i);
      valid_i = 1'b0;
      // Edges counted after the accepting one
      edges   = 0;
      while (!valid_o) begin
        @(negedge clk_i);
        edges++;
      end
      if (edges != `TS_READ_LAT + 1) begin
        report_mismatch("valid_o latency", 32'(`TS_READ_LAT + 1), 32'(edges));
      end
      if (res_o.hit !== exp_res.hit) begin
        report_mismatch("res_o.hit", 32'(exp_res.hit), 32'(res_o.hit));
      end
      if (res_o.evict !== exp_res.evict) begin
        report_mismatch("res_o.evict", 32'(exp_res.evict), 32'(res_o.evict));
      end
      if (res_o.indicator !== exp_res.indicator) begin
        report_mismatch("res_o.indicator", 32'(exp_res.indicator), 32'(res_o.indicator));
      end
      if (res_o.evict_tag !== exp_res.evict_tag) begin
        report_mismatch("res_o.evict_tag", 32'(exp_res.evict_tag), 32'(res_o.evict_tag));
      end
      // Back-pressure
      repeat (stall) begin
        @(negedge clk_i);
        if (valid_o !== 1'b1) begin
          report_mismatch("valid_o", 32'd1, 32'(valid_o));
        end
        if (res_o !== exp_res) begin
          report_mismatch("res_o", 32'(exp_res), 32'(res_o));
        end
        if (ready_o !== 1'b0) begin
          report_mismatch("ready_o", 32'd0, 32'(ready_o));
        end
      end
      ready_i = 1'b1;
      @(negedge clk_i);
      ready_i = 1'b0;
      // Write cycle
      if (valid_o !== 1'b0) begin
        report_mismatch("valid_o", 32'd0, 32'(valid_o));
      end
      if (ready_o !== 1'b0) begin
        report_mismatch("ready_o", 32'd0, 32'(ready_o));
      end
      @(negedge clk_i);
      if (ready_o !== 1'b1) begin
        report_mismatch("ready_o", 32'd1, 32'(ready_o));
      end
      if (err_cnt == test_start) begin
        passed++;
        $display("test %0d passed, stall %0d", t, stall);
      end else begin
        failed++;
        $display("test %0d failed with %0d errors", t, err_cnt - test_start);
      end
    end

    $display("tests %0d, passed %0d, failed %0d, errors %0d", n_tests, passed, failed,
             err_cnt);
    if (err_cnt == 0) begin
      $display("Finished with no errors");
    end else begin
      $display("Finished with errors");
    end
    $finish;
  end

endmodule
